//--- flist.f
rtl/drum_pkg.sv
rtl/drum_node.sv
rtl/drum_column.sv
rtl/center_tap.sv
rtl/sweep_ctrl.sv
rtl/audio_fifo_writer.sv
rtl/drum_top.sv
bench/drum_sva.sv
bench/drum_tb.sv

//--- Bender.yml
package:
  name: drum_synth

sources:
  - rtl/drum_pkg.sv
  - rtl/drum_node.sv
  - rtl/drum_column.sv
  - rtl/center_tap.sv
  - rtl/sweep_ctrl.sv
  - rtl/audio_fifo_writer.sv
  - rtl/drum_top.sv
  - target: simulation
    files:
      - bench/drum_sva.sv
      - bench/drum_tb.sv

//--- bench/drum_tb.sv
`default_nettype none

module drum_tb;
	import drum_pkg::*;

	localparam int NUM_COLS    = 5;
	localparam int MAX_CASES   = 8;
	localparam int MAX_SAMPLES = 48;

	typedef struct packed {
		row_idx_t   num_rows;
		amp_t       init_step;
		logic [1:0] gain_shift;
		logic [7:0] space_max;
		logic [7:0] samples;
		logic       mid_restart;
	} case_t;

	logic       CLOCK_50;
	logic       arst_n;
	logic       restart;
	row_idx_t   num_rows;
	amp_t       init_step;
	logic [1:0] gain_shift;
	bus_req_t   bus;
	logic       bus_ack = 1'b0;
	bus_word_t  bus_read_data = '0;

	case_t       cases [MAX_CASES];
	int          num_cases = 0;
	bit [31:0]   model_words [MAX_SAMPLES];
	bit [31:0]   left_words [$];
	logic [31:0] rng_state = 32'h77ec45f0;

	// Bus-slave model state
	logic      ack_enable = 1'b0;
	logic      stall = 1'b0;
	int        space_max = 8;
	logic      busy = 1'b0;
	int        ack_delay = 0;
	int        last_space = 0;
	int        read_count = 0;
	logic      left_pending = 1'b0;
	bit [31:0] left_data = '0;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	drum_top #(
		.NUM_COLS (NUM_COLS)
	) i_drum_top (
		.CLOCK_50      (CLOCK_50),
		.arst_n        (arst_n),
		.restart       (restart),
		.num_rows      (num_rows),
		.init_step     (init_step),
		.gain_shift    (gain_shift),
		.bus           (bus),
		.bus_ack       (bus_ack),
		.bus_read_data (bus_read_data)
	);

	bind audio_fifo_writer drum_sva i_drum_sva (
		.CLOCK_50     (CLOCK_50),
		.arst_n       (arst_n),
		.bus          (bus),
		.bus_ack      (bus_ack),
		.sample_taken (sample_taken)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #20 CLOCK_50 = ~CLOCK_50;
	end

	always @(posedge CLOCK_50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	//////////////////////////////////////////////////
	// Reference grid model
	//////////////////////////////////////////////////

	function automatic int wrap18(input longint x);
		logic [17:0] t;
		t = x[17:0];
		if (t[17]) begin
			return int'(t) - 262144;
		end
		return int'(t);
	endfunction

	// 1.17 product, sign bit and bits 33..17 of the full product
	function automatic int mul_q17(input int a, input int b);
		longint prod;
		longint kept;
		prod = longint'(a) * longint'(b);
		kept = (prod >>> 17) & 64'h1ffff;
		if (prod < 0) begin
			kept = kept | 64'h20000;
		end
		return wrap18(kept);
	endfunction

	task automatic build_model(input int rows, input int step, input int gain, input int count);
		int u [NUM_COLS][MAX_ROWS];
		int p [NUM_COLS][MAX_ROWS];
		int nx [NUM_COLS][MAX_ROWS];
		int dc, dr, lap, drive, rho, g, sample;
		int left, right, up, down;
		sample = 0;
		for (int c = 0; c < NUM_COLS; c++) begin
			for (int r = 0; r < rows; r++) begin
				dc = (c < NUM_COLS - 1 - c) ? c : NUM_COLS - 1 - c;
				dr = (r < rows - 1 - r) ? r : rows - 1 - r;
				u[c][r] = wrap18(longint'(step) * ((dc < dr) ? dc : dr));
				p[c][r] = u[c][r];
			end
		end
		for (int k = 0; k < count; k++) begin
			g = (sample >>> 3) >>> gain;
			rho = wrap18(int'(RHO_BASE) + mul_q17(g, g));
			if (rho > int'(RHO_MAX)) begin
				rho = int'(RHO_MAX);
			end
			for (int c = 0; c < NUM_COLS; c++) begin
				for (int r = 0; r < rows; r++) begin
					left  = (c > 0) ? u[c - 1][r] : 0;
					right = (c < NUM_COLS - 1) ? u[c + 1][r] : 0;
					down  = (r > 0) ? u[c][r - 1] : 0;
					up    = (r < rows - 1) ? u[c][r + 1] : 0;
					lap   = wrap18(left + right + up + down - 4 * u[c][r]);
					drive = wrap18(mul_q17(lap, rho) + 2 * u[c][r] - p[c][r] + (p[c][r] >>> 10));
					nx[c][r] = wrap18(drive - (drive >>> 9));
				end
			end
			p = u;
			u = nx;
			sample = u[NUM_COLS / 2][rows / 2];
			model_words[k] = sample << 14;
		end
	endtask

	//////////////////////////////////////////////////
	// Bus-slave model
	//////////////////////////////////////////////////

	task automatic answer_read();
		int space;
		checks++;
		assert (bus.addr == AUDIO_FIFO_ADDR) else begin
			$display("[FAIL] %0t: read from %h, expected the FIFO space register",
				$time, bus.addr);
			errors++;
		end
		if (stall) begin
			space = 0;
		end else begin
			space = next_random() % (space_max + 1);
		end
		bus_read_data <= {8'(space), 24'h0};
		last_space = space;
		read_count++;
	endtask

	task automatic answer_write();
		checks++;
		assert (last_space > FIFO_MIN_SPACE) else begin
			$display("[FAIL] %0t: write after the FIFO reported a space of %0d",
				$time, last_space);
			errors++;
		end
		checks++;
		assert ((bus.addr == AUDIO_LEFT_ADDR) || (bus.addr == AUDIO_RIGHT_ADDR)) else begin
			$display("[FAIL] %0t: write to unknown address %h", $time, bus.addr);
			errors++;
		end
		if (bus.addr == AUDIO_LEFT_ADDR) begin
			checks++;
			assert (!left_pending) else begin
				$display("[FAIL] %0t: left write with no right write after the last one",
					$time);
				errors++;
			end
			left_pending = 1'b1;
			left_data = bus.write_data;
			left_words.push_back(bus.write_data);
		end else if (bus.addr == AUDIO_RIGHT_ADDR) begin
			checks++;
			assert (left_pending && (bus.write_data == left_data)) else begin
				$display("[FAIL] %0t: right word %h does not match left word %h",
					$time, bus.write_data, left_data);
				errors++;
			end
			left_pending = 1'b0;
		end
	endtask

	// Ack one to three cycles after the strobe shows up
	always @(posedge CLOCK_50) begin
		if (bus_ack) begin
			bus_ack <= 1'b0;
		end else if (ack_enable && (bus.read || bus.write)) begin
			if (!busy) begin
				busy = 1'b1;
				ack_delay = next_random() % 3;
			end
			if (ack_delay == 0) begin
				busy = 1'b0;
				bus_ack <= 1'b1;
				if (bus.read) begin
					answer_read();
				end else begin
					answer_write();
				end
			end else begin
				ack_delay--;
			end
		end
	end

	//////////////////////////////////////////////////
	// Case sequencing
	//////////////////////////////////////////////////

	task automatic add_case(input int rows, input int step, input int gain, input int space,
			input int samples, input bit mid);
		case_t tc;
		tc.num_rows    = row_idx_t'(rows);
		tc.init_step   = amp_t'(step);
		tc.gain_shift  = 2'(gain);
		tc.space_max   = 8'(space);
		tc.samples     = 8'(samples);
		tc.mid_restart = mid;
		cases[num_cases] = tc;
		num_cases++;
	endtask

	task automatic check_first_request();
		int waited;
		waited = 0;
		@(negedge CLOCK_50);
		while (!(bus.read || bus.write) && (waited < 10)) begin
			@(negedge CLOCK_50);
			waited++;
		end
		checks++;
		assert (bus.read && !bus.write && (bus.addr == AUDIO_FIFO_ADDR)) else begin
			$display("[FAIL] %0t: first request is not a read of the FIFO space", $time);
			errors++;
		end
		// No ack yet, so the read must just wait
		repeat (6) begin
			@(negedge CLOCK_50);
			checks++;
			assert (bus.read && !bus.write) else begin
				$display("[FAIL] %0t: request changed while no ack came", $time);
				errors++;
			end
		end
		@(posedge CLOCK_50);
		ack_enable <= 1'b1;
	endtask

	// Hold the FIFO full until the writer only polls
	task automatic quiesce_writer();
		int reads_seen;
		@(posedge CLOCK_50);
		stall <= 1'b1;
		@(negedge CLOCK_50);
		reads_seen = read_count;
		while (read_count < reads_seen + 2) begin
			@(negedge CLOCK_50);
		end
	endtask

	task automatic restart_grid(input case_t tc);
		quiesce_writer();
		@(posedge CLOCK_50);
		num_rows   <= tc.num_rows;
		init_step  <= tc.init_step;
		gain_shift <= tc.gain_shift;
		space_max  <= tc.space_max;
		restart    <= 1'b1;
		@(posedge CLOCK_50);
		restart <= 1'b0;
		stall   <= 1'b0;
		left_words.delete();
	endtask

	task automatic collect_samples(input int count);
		while (left_words.size() < count) begin
			@(negedge CLOCK_50);
		end
	endtask

	task automatic check_samples(input int model_len, input bit zero_step, inout int checked);
		int n;
		n = left_words.size();
		if (n > model_len) begin
			n = model_len;
		end
		for (int k = 0; k < n; k++) begin
			checks++;
			checked++;
			assert (left_words[k] == model_words[k]) else begin
				$display("[FAIL] %0t: sample %0d is %h, expected %h",
					$time, k, left_words[k], model_words[k]);
				errors++;
			end
			if (zero_step) begin
				checks++;
				assert (left_words[k] == 32'h0) else begin
					$display("[FAIL] %0t: flat grid wrote %h", $time, left_words[k]);
					errors++;
				end
			end
		end
	endtask

	task automatic run_case(input int idx);
		case_t tc;
		int    first_errors;
		int    model_len;
		int    checked;
		tc = cases[idx];
		first_errors = errors;
		checked = 0;
		model_len = tc.samples + 8;
		build_model(tc.num_rows, wrap18(tc.init_step), tc.gain_shift, model_len);
		restart_grid(tc);
		if (tc.mid_restart) begin
			collect_samples(tc.samples / 2);
			check_samples(model_len, tc.init_step == '0, checked);
			// Sequence starts over from the pyramid
			restart_grid(tc);
		end
		collect_samples(tc.samples);
		check_samples(model_len, tc.init_step == '0, checked);
		$display("case %0d: %0d rows, step %h, gain shift %0d, %0d words checked, %0d errors",
			idx, tc.num_rows, tc.init_step, tc.gain_shift, checked, errors - first_errors);
	endtask

	initial begin
		int total;
		arst_n     = 1'b0;
		restart    = 1'b0;
		num_rows   = row_idx_t'(3);
		init_step  = '0;
		gain_shift = 2'd0;

		// rows, step, gain shift, max FIFO space, samples, restart midway
		add_case(3, 18'h04000, 0, 8, 12, 1'b0);
		add_case(5, 18'h02000, 1, 6, 14, 1'b0);
		add_case(8, 18'h03000, 2, 10, 10, 1'b0);
		add_case(6, 18'h00000, 3, 7, 8, 1'b0);
		add_case(7, 18'h3e000, 1, 5, 10, 1'b1);
		add_case(4, 18'h05000, 3, 9, 12, 1'b0);

		total = 0;
		for (int i = 0; i < num_cases; i++) begin
			total += cases[i].samples * (2 * cases[i].num_rows + 40);
		end
		cycle_limit = 40 * total;

		repeat (2) @(posedge CLOCK_50);
		arst_n <= 1'b1;
		check_first_request();

		for (int i = 0; i < num_cases; i++) begin
			run_case(i);
		end

		errors += i_drum_top.i_writer.i_drum_sva.fail_count;
		$display("%0d cases, %0d checks, %0d errors", num_cases, checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/drum_sva.sv
`default_nettype none

module drum_sva (
	input wire                     CLOCK_50,
	input wire                     arst_n,
	input wire drum_pkg::bus_req_t bus,
	input wire                     bus_ack,
	input wire                     sample_taken
);
	import drum_pkg::*;

	// Failure total for the end-of-run summary
	int unsigned fail_count = 0;

	// One strobe at a time
	a_one_strobe: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		!(bus.read && bus.write))
	else begin
		$error("bus read and write are high in the same cycle");
		fail_count++;
	end

	// A request waiting for ack keeps its address, data and strobe
	a_hold_request: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		((bus.read || bus.write) && !bus_ack) |=>
		($stable(bus.addr) && $stable(bus.write_data) && $stable(bus.read) &&
		$stable(bus.write)))
	else begin
		$error("bus request changed before its ack");
		fail_count++;
	end

	a_taken_after_left: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		sample_taken |-> $past(bus.write && bus_ack && (bus.addr == AUDIO_LEFT_ADDR)))
	else begin
		$error("sample_taken without an acked left channel write");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- rtl/drum_top.sv
`default_nettype none

module drum_top #(
	parameter int NUM_COLS = 5
) (
	input  wire                      CLOCK_50,
	input  wire                      arst_n,
	input  wire                      restart,
	input  wire drum_pkg::row_idx_t  num_rows,
	input  wire drum_pkg::amp_t      init_step,
	input  wire [1:0]                gain_shift,
	output drum_pkg::bus_req_t       bus,
	input  wire                      bus_ack,
	input  wire drum_pkg::bus_word_t bus_read_data
);
	import drum_pkg::*;

	sweep_state_t phase;
	row_idx_t     row;
	row_idx_t     load_rows;
	logic         center_strobe;
	logic         step_done;
	logic         sample_ready;
	logic         sample_taken;
	amp_t         sample;
	rho_t         rho;
	amp_t         center_u;

	// Current values with a zero column on each side for the fixed edges
	wire amp_t col_cur [NUM_COLS + 2];
	wire amp_t col_next [NUM_COLS];

	assign col_cur[0]            = '0;
	assign col_cur[NUM_COLS + 1] = '0;

	sweep_ctrl #(
		.NUM_COLS (NUM_COLS)
	) i_sweep_ctrl (
		.CLOCK_50      (CLOCK_50),
		.arst_n        (arst_n),
		.restart       (restart),
		.num_rows      (num_rows),
		.sample_taken  (sample_taken),
		.phase         (phase),
		.row           (row),
		.load_rows     (load_rows),
		.center_strobe (center_strobe),
		.step_done     (step_done),
		.sample_ready  (sample_ready)
	);

	//////////////////////////////////////////////////
	// Column array, all on the same row each cycle
	//////////////////////////////////////////////////

	for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
		drum_column #(
			.NUM_COLS  (NUM_COLS),
			.COL_INDEX (c)
		) i_column (
			.CLOCK_50  (CLOCK_50),
			.arst_n    (arst_n),
			.phase     (phase),
			.row       (row),
			.load_rows (load_rows),
			.init_step (init_step),
			.rho       (rho),
			.left_u    (col_cur[c]),
			.right_u   (col_cur[c + 2]),
			.cur_u     (col_cur[c + 1]),
			.next_u    (col_next[c])
		);
	end

	// Audio comes from the middle column
	assign center_u = col_next[NUM_COLS / 2];

	center_tap i_center_tap (
		.CLOCK_50      (CLOCK_50),
		.arst_n        (arst_n),
		.center_strobe (center_strobe),
		.step_done     (step_done),
		.center_u      (center_u),
		.gain_shift    (gain_shift),
		.sample        (sample),
		.rho           (rho)
	);

	audio_fifo_writer i_writer (
		.CLOCK_50      (CLOCK_50),
		.arst_n        (arst_n),
		.sample        (sample),
		.sample_ready  (sample_ready),
		.bus_ack       (bus_ack),
		.bus_read_data (bus_read_data),
		.bus           (bus),
		.sample_taken  (sample_taken)
	);

endmodule

`default_nettype wire

//--- rtl/audio_fifo_writer.sv
`default_nettype none

module audio_fifo_writer (
	input  wire                      CLOCK_50,
	input  wire                      arst_n,
	input  wire drum_pkg::amp_t      sample,
	input  wire                      sample_ready,
	input  wire                      bus_ack,
	input  wire drum_pkg::bus_word_t bus_read_data,
	output drum_pkg::bus_req_t       bus,
	output logic                     sample_taken
);
	import drum_pkg::*;

	writer_state_t state;
	logic [7:0]    fifo_space;
	bus_word_t     sample_word;
	logic          go_write;

	// Room in the FIFO and a fresh sample waiting
	assign go_write = (state == DECIDE) && (fifo_space > FIFO_MIN_SPACE) && sample_ready;

	always_ff @(posedge CLOCK_50) begin
		// Free space sits in the top byte
		if ((state == WAIT_SPACE) && bus_ack) begin
			fifo_space <= bus_read_data[31:24];
		end
		// Same word for both channels
		if (go_write) begin
			sample_word <= {{14{sample[17]}}, sample} << 14;
		end
	end

	//////////////////////////////////////////////////
	// Bus master FSM
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state        <= RD_SPACE;
			bus          <= '0;
			sample_taken <= 1'b0;
		end else begin
			sample_taken <= 1'b0;
			case (state)
				RD_SPACE: begin
					bus.addr <= AUDIO_FIFO_ADDR;
					bus.read <= 1'b1;
					state    <= WAIT_SPACE;
				end
				WAIT_SPACE: begin
					if (bus_ack) begin
						bus.read <= 1'b0;
						state    <= DECIDE;
					end
				end
				DECIDE: begin
					// No room or no sample, poll again
					state <= go_write ? WR_LEFT : RD_SPACE;
				end
				WR_LEFT: begin
					bus.addr       <= AUDIO_LEFT_ADDR;
					bus.write_data <= sample_word;
					bus.write      <= 1'b1;
					state          <= WAIT_LEFT;
				end
				WAIT_LEFT: begin
					if (bus_ack) begin
						bus.write    <= 1'b0;
						sample_taken <= 1'b1;
						state        <= WR_RIGHT;
					end
				end
				WR_RIGHT: begin
					bus.addr       <= AUDIO_RIGHT_ADDR;
					bus.write_data <= sample_word;
					bus.write      <= 1'b1;
					state          <= WAIT_RIGHT;
				end
				WAIT_RIGHT: begin
					if (bus_ack) begin
						bus.write <= 1'b0;
						state     <= RD_SPACE;
					end
				end
				default: begin
					state <= RD_SPACE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/sweep_ctrl.sv
`default_nettype none

module sweep_ctrl #(
	parameter int NUM_COLS = 5
) (
	input  wire                     CLOCK_50,
	input  wire                     arst_n,
	input  wire                     restart,
	input  wire drum_pkg::row_idx_t num_rows,
	input  wire                     sample_taken,
	output drum_pkg::sweep_state_t  phase,
	output drum_pkg::row_idx_t      row,
	output drum_pkg::row_idx_t      load_rows,
	output logic                    center_strobe,
	output logic                    step_done,
	output logic                    sample_ready
);
	import drum_pkg::*;

	sweep_state_t state;
	row_idx_t     center_row;
	logic         last_row;

	// The centre node needs an odd column count
	if (NUM_COLS % 2 == 0) begin : g_bad_cols
		$error("sweep_ctrl needs an odd NUM_COLS");
	end

	assign phase      = state;
	assign center_row = load_rows >> 1;
	assign last_row   = (row == load_rows - 1'b1);

	// In INIT the grid yields zero here, which clears the sample
	assign center_strobe = ((state == INIT) || (state == STEP)) && (row == center_row);

	assign sample_ready = (state == HOLD);

	//////////////////////////////////////////////////
	// Sweep sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			row       <= '0;
			load_rows <= '0;
			step_done <= 1'b0;
		end else begin
			step_done <= 1'b0;
			if (restart || (state == IDLE)) begin
				state     <= INIT;
				row       <= '0;
				load_rows <= num_rows;
			end else begin
				case (state)
					INIT: begin
						if (last_row) begin
							// Also loads the base tension for the first step
							state     <= PRIME;
							row       <= '0;
							step_done <= 1'b1;
						end else begin
							row <= row + 1'b1;
						end
					end
					PRIME: begin
						state <= STEP;
					end
					STEP: begin
						if (last_row) begin
							state     <= HOLD;
							row       <= '0;
							step_done <= 1'b1;
						end else begin
							row <= row + 1'b1;
						end
					end
					HOLD: begin
						// Wait until the writer has taken the sample
						if (sample_taken) begin
							state <= PRIME;
						end
					end
					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/center_tap.sv
`default_nettype none

module center_tap (
	input  wire                 CLOCK_50,
	input  wire                 arst_n,
	input  wire                 center_strobe,
	input  wire                 step_done,
	input  wire drum_pkg::amp_t center_u,
	input  wire [1:0]           gain_shift,
	output drum_pkg::amp_t      sample,
	output drum_pkg::rho_t      rho
);
	import drum_pkg::*;

	amp_t gain_u;
	amp_t gain_sq;
	rho_t rho_sum;

	// Tension grows with the square of the centre amplitude
	assign gain_u  = (sample >>> 3) >>> gain_shift;
	assign gain_sq = fixmul(gain_u, gain_u);
	assign rho_sum = RHO_BASE + gain_sq;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			sample <= '0;
			rho    <= RHO_BASE;
		end else begin
			if (center_strobe) begin
				sample <= center_u;
			end
			// Held for the whole next sweep
			if (step_done) begin
				rho <= (rho_sum > RHO_MAX) ? RHO_MAX : rho_sum;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/drum_column.sv
`default_nettype none

module drum_column #(
	parameter int NUM_COLS  = 5,
	parameter int COL_INDEX = 0
) (
	input  wire                         CLOCK_50,
	input  wire                         arst_n,
	input  wire drum_pkg::sweep_state_t phase,
	input  wire drum_pkg::row_idx_t     row,
	input  wire drum_pkg::row_idx_t     load_rows,
	input  wire drum_pkg::amp_t         init_step,
	input  wire drum_pkg::rho_t         rho,
	input  wire drum_pkg::amp_t         left_u,
	input  wire drum_pkg::amp_t         right_u,
	output drum_pkg::amp_t              cur_u,
	output drum_pkg::amp_t              next_u
);
	import drum_pkg::*;

	// Distance to the nearer fixed edge caps the pyramid height here
	localparam int COL_DIST = (COL_INDEX < NUM_COLS - 1 - COL_INDEX) ?
		COL_INDEX : NUM_COLS - 1 - COL_INDEX;
	localparam row_idx_t COL_LEVEL = row_idx_t'(COL_DIST);

	amp_t     cur_mem [MAX_ROWS];
	amp_t     prev_mem [MAX_ROWS];
	amp_t     cur_q;
	amp_t     prev_q;
	row_idx_t cur_rd_addr;
	row_idx_t prev_rd_addr;
	logic     mem_we;
	amp_t     cur_wr_data;
	amp_t     prev_wr_data;

	amp_t     cur_reg;
	amp_t     down_reg;
	amp_t     up_u;
	amp_t     down_u;
	amp_t     node_next;

	amp_t     init_acc;
	row_idx_t init_level;
	amp_t     init_val;
	row_idx_t init_base;
	row_idx_t next_row;
	row_idx_t next_mirror;
	row_idx_t next_dist;
	row_idx_t next_level;

	//////////////////////////////////////////////////
	// Pyramid initializer
	//////////////////////////////////////////////////

	// Row 0 always starts from zero, even after a restart inside INIT
	assign init_val  = (row == '0) ? '0 : init_acc;
	assign init_base = (row == '0) ? '0 : init_level;

	// Level of the row written next cycle
	assign next_row    = row + 1'b1;
	assign next_mirror = load_rows - next_row - 1'b1;
	assign next_dist   = (next_row < next_mirror) ? next_row : next_mirror;
	assign next_level  = (next_dist < COL_LEVEL) ? next_dist : COL_LEVEL;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			init_acc   <= '0;
			init_level <= '0;
		end else if (phase == INIT) begin
			init_level <= next_level;
			if (next_level > init_base) begin
				init_acc <= init_val + init_step;
			end else if (next_level < init_base) begin
				init_acc <= init_val - init_step;
			end else begin
				init_acc <= init_val;
			end
		end
	end

	//////////////////////////////////////////////////
	// Row memories
	//////////////////////////////////////////////////

	assign mem_we       = (phase == INIT) || (phase == STEP);
	assign cur_wr_data  = (phase == INIT) ? init_val : node_next;
	assign prev_wr_data = (phase == INIT) ? init_val : cur_reg;

	// Current memory runs two rows ahead, so the row above is ready in time
	assign cur_rd_addr  = (phase == STEP) ? row + 2'd2 :
		(phase == PRIME) ? row_idx_t'(1) : '0;
	assign prev_rd_addr = (phase == STEP) ? next_row : '0;

	always_ff @(posedge CLOCK_50) begin
		if (mem_we) begin
			cur_mem[row]  <= cur_wr_data;
			prev_mem[row] <= prev_wr_data;
		end
		cur_q  <= cur_mem[cur_rd_addr];
		prev_q <= prev_mem[prev_rd_addr];
	end

	// Shift the column up by one row per cycle
	always_ff @(posedge CLOCK_50) begin
		if ((phase == PRIME) || (phase == STEP)) begin
			cur_reg  <= cur_q;
			down_reg <= cur_reg;
		end
	end

	// Fixed boundary above the top row and below row 0
	assign up_u   = (row == load_rows - 1'b1) ? '0 : cur_q;
	assign down_u = (row == '0) ? '0 : down_reg;

	drum_node i_node (
		.rho     (rho),
		.cur_u   (cur_reg),
		.prev_u  (prev_q),
		.left_u  (left_u),
		.right_u (right_u),
		.up_u    (up_u),
		.down_u  (down_u),
		.next_u  (node_next)
	);

	assign cur_u = cur_reg;

	// New value only while stepping, zero otherwise
	assign next_u = (phase == STEP) ? node_next : '0;

endmodule

`default_nettype wire

//--- rtl/drum_node.sv
`default_nettype none

module drum_node (
	input  wire drum_pkg::rho_t rho,
	input  wire drum_pkg::amp_t cur_u,
	input  wire drum_pkg::amp_t prev_u,
	input  wire drum_pkg::amp_t left_u,
	input  wire drum_pkg::amp_t right_u,
	input  wire drum_pkg::amp_t up_u,
	input  wire drum_pkg::amp_t down_u,
	output drum_pkg::amp_t      next_u
);
	import drum_pkg::*;

	amp_t lap;
	amp_t lap_rho;
	amp_t leap;

	// Discrete Laplacian over the four neighbours, wraps at 18 bits
	assign lap = (left_u - cur_u) + (right_u - cur_u) + (up_u - cur_u) + (down_u - cur_u);

	assign lap_rho = fixmul(lap, rho);

	// Leapfrog term with a light pull on the previous value
	assign leap = lap_rho + (cur_u <<< 1) - prev_u + (prev_u >>> 10);

	// Damping
	assign next_u = leap - (leap >>> 9);

endmodule

`default_nettype wire

//--- rtl/drum_pkg.sv
`default_nettype none

package drum_pkg;

	//////////////////////////////////////////////////
	// Fixed-point types, 1.17 two's complement
	//////////////////////////////////////////////////

	typedef logic signed [17:0] amp_t;
	typedef logic signed [17:0] rho_t;

	// Deepest column the row memories hold
	localparam int MAX_ROWS = 32;
	typedef logic [4:0] row_idx_t;

	//////////////////////////////////////////////////
	// Bus master request and audio core register map
	//////////////////////////////////////////////////

	typedef logic [31:0] bus_word_t;

	typedef struct packed {
		bus_word_t addr;
		logic      read;
		logic      write;
		bus_word_t write_data;
	} bus_req_t;

	localparam bus_word_t AUDIO_FIFO_ADDR  = 32'h3044;
	localparam bus_word_t AUDIO_LEFT_ADDR  = 32'h3048;
	localparam bus_word_t AUDIO_RIGHT_ADDR = 32'h304c;

	// Free words needed before a sample pair goes out
	localparam logic [7:0] FIFO_MIN_SPACE = 8'd2;

	// Tension range
	localparam rho_t RHO_BASE = 18'h08000;
	localparam rho_t RHO_MAX  = 18'h0fae1;

	typedef enum logic [2:0] {IDLE, INIT, PRIME, STEP, HOLD} sweep_state_t;

	typedef enum logic [2:0] {
		RD_SPACE, WAIT_SPACE, DECIDE, WR_LEFT, WAIT_LEFT, WR_RIGHT, WAIT_RIGHT
	} writer_state_t;

	// 1.17 multiply keeping the sign and bits 33..17
	function automatic amp_t fixmul(amp_t a, amp_t b);
		logic signed [35:0] prod;
		prod = a * b;
		return {prod[35], prod[33:17]};
	endfunction

endpackage

`default_nettype wire
